//--- frame_buf_pkg.sv
// frame buffer shared definitions
// sizes, address fields, stream data-type codes, burst and descriptor types
package frame_buf_pkg;

   localparam int num_banks    = 4;
   localparam int burst_words  = 16;    // 32-bit words, 64 bytes
   localparam int bank_bursts  = 64;
   localparam int addr_width   = 14;    // 16 KB, addresses wrap
   localparam int header_words = 8;
   localparam int queue_depth  = 4;
   localparam int dtype_width  = 4;

   // byte address is | burst_idx | bank | byte in burst |
   localparam int burst_bytes    = burst_words * 4;
   localparam int burst_shift    = $clog2(burst_bytes);
   localparam int bank_width     = $clog2(num_banks);
   localparam int idx_width      = $clog2(bank_bursts);
   localparam int word_sel_width = $clog2(burst_words);
   localparam int cnt_width      = word_sel_width + 1;

   typedef logic [dtype_width-1:0] dtype_t;

   localparam dtype_t dtype_frame_start  = 4'h0;
   localparam dtype_t dtype_frame_end    = 4'h1;
   localparam dtype_t dtype_header_start = 4'h2;
   localparam dtype_t dtype_header_end   = 4'h3;
   localparam dtype_t dtype_pixel        = 4'h4;
   localparam dtype_t dtype_header       = 4'h5;
   localparam dtype_t dtype_other        = 4'hf;  // never stored

   typedef logic [burst_words-1:0][31:0] burst_t;

   typedef struct packed {
      logic [addr_width-1:0] base;   // byte address of the header burst
      logic [addr_width-1:0] len;    // bytes, multiple of 64
   } frame_desc_t;

endpackage

//--- burst_if.sv
// burst channel between a requesting port and one memory bank
// four-phase req/ack, one whole burst per handshake
interface burst_if;
   import frame_buf_pkg::*;

   logic                 req;
   logic                 ack;
   logic [idx_width-1:0] burst_idx;
   burst_t               wdata;
   burst_t               rdata;   // valid while ack is high on a read

   modport port (
      output req,
      output burst_idx,
      output wdata,
      input  ack,
      input  rdata
   );

   modport bank (
      input  req,
      input  burst_idx,
      input  wdata,
      output ack,
      output rdata
   );

endinterface

//--- stream_writer.sv
// stream writer
// decodes the typed 16-bit stream, packs pixel pairs into 32-bit words and
// writes 64-byte bursts through two ping-pong buffers. the header goes in
// last, at the frame base, and the frame is then committed or dropped
module stream_writer (
   input  logic                       rclk,
   input  logic                       resetb,
   input  logic                       enable,
   input  logic                       dvi,
   input  frame_buf_pkg::dtype_t      dtypei,
   input  logic [15:0]                datai,
   input  logic                       queue_full,
   output logic                       push,
   output frame_buf_pkg::frame_desc_t push_desc,
   burst_if.port                      wr_ch [frame_buf_pkg::num_banks]
);
   import frame_buf_pkg::*;

   typedef enum logic [1:0] {tx_idle, tx_req, tx_rel} tx_st_t;

   logic                            s_v;
   dtype_t                          s_type;
   logic [15:0]                     s_data;
   logic                            active;       // inside a frame
   logic [addr_width-1:0]           base;
   logic [addr_width-1:0]           waddr;        // burst being filled
   logic [addr_width-1:0]           flen;         // rounded length
   logic [word_sel_width-1:0]       wcnt;
   logic                            half;
   logic [15:0]                     lo;
   logic [$clog2(header_words)-1:0] hcnt;
   burst_t                          bufs [2];
   logic [addr_width-1:0]           baddr [2];
   logic [1:0]                      pend;
   logic                            fb;           // buffer being filled
   logic                            tx_buf;
   tx_st_t                          tx_st;
   logic [bank_width-1:0]           tx_bank;
   logic [num_banks-1:0]            ch_ack;
   logic                            store;
   logic                            word_done;
   logic                            flush;
   logic                            burst_done;
   logic [31:0]                     len_ext;
   logic [15:0]                     item_data;

   assign store      = s_v && active && (s_type == dtype_pixel || s_type == dtype_header);
   assign word_done  = store && half;
   assign flush      = s_v && active && (wcnt != '0 || half) &&
                       (s_type == dtype_frame_end || s_type == dtype_header_end);
   assign burst_done = (word_done && &wcnt) || flush;

   // header words 0 and 1 carry the rounded length
   assign len_ext   = 32'(flen);
   assign item_data = (s_type != dtype_header) ? s_data :
                      (hcnt == 0)              ? len_ext[15:0] :
                      (hcnt == 1)              ? len_ext[31:16] : s_data;

   assign tx_bank = baddr[tx_buf][burst_shift +: bank_width];

   for (genvar k = 0; k < num_banks; k++) begin : g_ch
      assign wr_ch[k].req       = (tx_st == tx_req) && (tx_bank == bank_width'(k));
      assign wr_ch[k].burst_idx = baddr[tx_buf][burst_shift+bank_width +: idx_width];
      assign wr_ch[k].wdata     = bufs[tx_buf];
      assign ch_ack[k]          = wr_ch[k].ack;
   end

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         s_v    <= 1'b0;
         active <= 1'b0;
         base   <= '0;
         waddr  <= '0;
         flen   <= '0;
         wcnt   <= '0;
         half   <= 1'b0;
         hcnt   <= '0;
         push   <= 1'b0;
         pend   <= '0;
         fb     <= 1'b0;
         tx_buf <= 1'b0;
         tx_st  <= tx_idle;
      end else begin
         s_v  <= dvi;
         push <= 1'b0;

         // one burst in flight at a time, buffers go out in fill order
         case (tx_st)
            tx_idle: if (pend[tx_buf]) tx_st <= tx_req;
            tx_req:  if (ch_ack[tx_bank]) tx_st <= tx_rel;
            default: begin
               if (!ch_ack[tx_bank]) begin
                  pend[tx_buf] <= 1'b0;
                  tx_buf       <= !tx_buf;
                  tx_st        <= tx_idle;
               end
            end
         endcase

         if (!enable) begin
            active <= 1'b0;
            base   <= '0;
            wcnt   <= '0;
            half   <= 1'b0;
         end else begin
            if (word_done) begin
               wcnt <= wcnt + 1'b1;
               half <= 1'b0;
            end else if (store) begin
               half <= 1'b1;
            end
            if (store && s_type == dtype_header)
               hcnt <= hcnt + 1'b1;
            if (burst_done) begin
               pend[fb] <= 1'b1;
               fb       <= !fb;
               waddr    <= waddr + addr_width'(burst_bytes);
            end
            if (flush) begin
               wcnt <= '0;
               half <= 1'b0;
            end

            if (s_v && s_type == dtype_frame_start) begin
               active <= 1'b1;
               waddr  <= base + addr_width'(burst_bytes);   // skip header burst
               wcnt   <= '0;
               half   <= 1'b0;
            end else if (s_v && active && s_type == dtype_frame_end) begin
               flen <= (flush ? waddr + addr_width'(burst_bytes) : waddr) - base;
            end else if (s_v && active && s_type == dtype_header_start) begin
               waddr <= base;
               wcnt  <= '0;
               half  <= 1'b0;
               hcnt  <= '0;
            end else if (s_v && active && s_type == dtype_header_end) begin
               active <= 1'b0;
               if (!queue_full) begin       // else drop, base stays put
                  push <= 1'b1;
                  base <= base + flen;
               end
            end
         end
      end
   end

   always_ff @(posedge rclk) begin
      s_type    <= dtypei;
      s_data    <= datai;
      push_desc <= '{base: base, len: flen};
      if (store && !half)
         lo <= item_data;               // low half first
      if (word_done)
         bufs[fb][wcnt] <= {item_data, lo};
      if (flush) begin
         for (int j = 0; j < burst_words; j++) begin
            if (j == wcnt && half)
               bufs[fb][j] <= {16'h0000, lo};
            else if (j >= wcnt)
               bufs[fb][j] <= '0;
         end
      end
      if (burst_done)
         baddr[fb] <= waddr;
   end

endmodule

//--- frame_queue.sv
// frame queue
// circular FIFO of committed frame descriptors, head shown combinationally
module frame_queue #(
   parameter type item_t = frame_buf_pkg::frame_desc_t
) (
   input  logic  rclk,
   input  logic  resetb,
   input  logic  flush,
   input  logic  push,
   input  item_t push_item,
   input  logic  pop,
   output item_t head,
   output logic  full,
   output logic  not_empty
);
   import frame_buf_pkg::*;

   localparam int ptr_width = $clog2(queue_depth);

   item_t                entries [queue_depth];
   logic [ptr_width-1:0] rptr;
   logic [ptr_width-1:0] wptr;
   logic [ptr_width:0]   count;
   logic                 do_push;
   logic                 do_pop;

   assign full      = (count == (ptr_width + 1)'(queue_depth));
   assign not_empty = (count != '0);
   assign head      = entries[rptr];
   assign do_push   = push && !full;
   assign do_pop    = pop && not_empty;

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end else if (flush) begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end else begin
         if (do_push)
            wptr <= wptr + 1'b1;
         if (do_pop)
            rptr <= rptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge rclk) begin
      if (do_push && !flush)
         entries[wptr] <= push_item;
   end

endmodule

//--- mem_bank.sv
// memory bank
// serves whole-burst writes and reads over two four-phase channels,
// one word per cycle, with the write channel first
module mem_bank (
   input logic   rclk,
   input logic   resetb,
   burst_if.bank wr_ch,
   burst_if.bank rd_ch
);
   import frame_buf_pkg::*;

   typedef enum logic [1:0] {b_idle, b_busy, b_ack} bank_st_t;

   bank_st_t                           st;
   logic                               sel_wr;
   logic [idx_width-1:0]               idx;
   logic [cnt_width-1:0]               cnt;
   logic [cnt_width-1:0]               last;
   logic                               word_go;
   logic                               cur_req;
   logic [idx_width+word_sel_width-1:0] maddr;
   logic [31:0]                        mem [bank_bursts*burst_words];
   burst_t                             rbuf;

   // a read takes one cycle more than a write
   assign last    = sel_wr ? cnt_width'(burst_words - 1) : cnt_width'(burst_words);
   assign word_go = (st == b_busy) && (cnt < cnt_width'(burst_words));
   assign maddr   = {idx, cnt[word_sel_width-1:0]};
   assign cur_req = sel_wr ? wr_ch.req : rd_ch.req;

   assign wr_ch.ack   = (st == b_ack) && sel_wr;
   assign rd_ch.ack   = (st == b_ack) && !sel_wr;
   assign rd_ch.rdata = rbuf;
   assign wr_ch.rdata = '0;

   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         st     <= b_idle;
         sel_wr <= 1'b0;
         idx    <= '0;
         cnt    <= '0;
      end else begin
         case (st)
            b_idle: begin
               cnt <= '0;
               if (wr_ch.req) begin
                  sel_wr <= 1'b1;
                  idx    <= wr_ch.burst_idx;
                  st     <= b_busy;
               end else if (rd_ch.req) begin
                  sel_wr <= 1'b0;
                  idx    <= rd_ch.burst_idx;
                  st     <= b_busy;
               end
            end
            b_busy: begin
               cnt <= cnt + 1'b1;
               if (cnt == last)
                  st <= b_ack;
            end
            default: if (!cur_req) st <= b_idle;   // hold ack until req drops
         endcase
      end
   end

   always_ff @(posedge rclk) begin
      if (word_go) begin
         if (sel_wr)
            mem[maddr] <= wr_ch.wdata[cnt[word_sel_width-1:0]];
         else
            rbuf[cnt[word_sel_width-1:0]] <= mem[maddr];
      end
   end

endmodule

//--- di_reader.sv
// device interface reader
// pops committed frames and plays them back as 16-bit words,
// fetching one burst at a time from the interleaved banks
module di_reader (
   input  logic                       rclk,
   input  logic                       resetb,
   input  logic                       enable,
   input  logic                       di_read_mode,
   input  logic                       di_read,
   output logic                       di_read_rdy,
   output logic [15:0]                di_reg_datao,
   input  logic                       not_empty,
   input  frame_buf_pkg::frame_desc_t head,
   output logic                       pop,
   burst_if.port                      rd_ch [frame_buf_pkg::num_banks]
);
   import frame_buf_pkg::*;

   typedef enum logic [2:0] {r_idle, r_req, r_rel, r_out, r_done} rd_st_t;

   rd_st_t                    st;
   logic [addr_width-1:0]     raddr;
   logic [addr_width-1:0]     rend;
   logic [addr_width-1:0]     next_raddr;
   logic [word_sel_width-1:0] wi;
   logic                      half;
   burst_t                    rbuf;
   logic [bank_width-1:0]     bank;
   logic [num_banks-1:0]      ch_ack;
   burst_t                    ch_rdata [num_banks];
   logic                      in_handshake;

   assign bank         = raddr[burst_shift +: bank_width];
   assign next_raddr   = raddr + addr_width'(burst_bytes);
   assign in_handshake = (st == r_req) || (st == r_rel);
   assign di_read_rdy  = (st == r_out);
   assign di_reg_datao = half ? rbuf[wi][31:16] : rbuf[wi][15:0];

   for (genvar k = 0; k < num_banks; k++) begin : g_ch
      assign rd_ch[k].req       = (st == r_req) && (bank == bank_width'(k));
      assign rd_ch[k].burst_idx = raddr[burst_shift+bank_width +: idx_width];
      assign rd_ch[k].wdata     = '0;
      assign ch_ack[k]          = rd_ch[k].ack;
      assign ch_rdata[k]        = rd_ch[k].rdata;
   end

   ////////////////////////////////////////////////////////////////////
   // playback FSM
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge rclk or negedge resetb) begin
      if (!resetb) begin
         st    <= r_idle;
         raddr <= '0;
         rend  <= '0;
         wi    <= '0;
         half  <= 1'b0;
         pop   <= 1'b0;
      end else begin
         pop <= 1'b0;
         // a running handshake always finishes first
         if ((!enable || !di_read_mode) && !in_handshake) begin
            st <= r_idle;
         end else begin
            case (st)
               r_idle: begin
                  if (not_empty) begin
                     pop   <= 1'b1;
                     raddr <= head.base;
                     rend  <= head.base + head.len;
                     st    <= r_req;
                  end else begin
                     st <= r_done;    // wait for the next read mode
                  end
               end
               r_req: if (ch_ack[bank]) st <= r_rel;
               r_rel: begin
                  if (!ch_ack[bank]) begin
                     wi   <= '0;
                     half <= 1'b0;
                     st   <= r_out;
                  end
               end
               r_out: begin
                  if (di_read) begin
                     half <= !half;
                     if (half) begin
                        wi <= wi + 1'b1;
                        if (&wi) begin     // burst used up
                           raddr <= next_raddr;
                           st    <= (next_raddr == rend) ? r_done : r_req;
                        end
                     end
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge rclk) begin
      if (st == r_req && ch_ack[bank])
         rbuf <= ch_rdata[bank];
   end

endmodule

//--- frame_buf_top.sv
// frame buffer top level
// stream writer, frame queue, interleaved banks and device interface reader
module frame_buf_top (
   input  logic                  rclk,
   input  logic                  resetb,
   input  logic                  enable,
   input  logic                  dvi,
   input  frame_buf_pkg::dtype_t dtypei,
   input  logic [15:0]           datai,
   input  logic                  di_read_mode,
   input  logic                  di_read,
   output logic                  di_read_rdy,
   output logic [15:0]           di_reg_datao
);
   import frame_buf_pkg::*;

   logic        queue_full;
   logic        push;
   logic        pop;
   logic        not_empty;
   frame_desc_t push_desc;
   frame_desc_t head;

   burst_if wr_ch [num_banks] ();
   burst_if rd_ch [num_banks] ();

   stream_writer u_writer (
      .rclk       (rclk),
      .resetb     (resetb),
      .enable     (enable),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .datai      (datai),
      .queue_full (queue_full),
      .push       (push),
      .push_desc  (push_desc),
      .wr_ch      (wr_ch)
   );

   frame_queue #(.item_t(frame_desc_t)) u_queue (
      .rclk      (rclk),
      .resetb    (resetb),
      .flush     (!enable),    // enable low empties the buffer
      .push      (push),
      .push_item (push_desc),
      .pop       (pop),
      .head      (head),
      .full      (queue_full),
      .not_empty (not_empty)
   );

   for (genvar k = 0; k < num_banks; k++) begin : g_bank
      mem_bank u_bank (
         .rclk   (rclk),
         .resetb (resetb),
         .wr_ch  (wr_ch[k]),
         .rd_ch  (rd_ch[k])
      );
   end

   di_reader u_reader (
      .rclk         (rclk),
      .resetb       (resetb),
      .enable       (enable),
      .di_read_mode (di_read_mode),
      .di_read      (di_read),
      .di_read_rdy  (di_read_rdy),
      .di_reg_datao (di_reg_datao),
      .not_empty    (not_empty),
      .head         (head),
      .pop          (pop),
      .rd_ch        (rd_ch)
   );

endmodule

//--- tb_frame_checker.sv
// frame buffer checker
// snoops the stream at the DUT ports, models the frame queue with its
// commit rule, builds each expected frame and compares the playback
module tb_frame_checker (
   input  logic                  rclk,
   input  logic                  resetb,
   input  logic                  enable,
   input  logic                  dvi,
   input  frame_buf_pkg::dtype_t dtypei,
   input  logic [15:0]           datai,
   input  logic                  di_read_mode,
   input  logic                  di_read,
   input  logic                  di_read_rdy,
   input  logic [15:0]           di_reg_datao,
   output int                    errors,
   output int                    checks
);
   timeunit 1ns;
   timeprecision 100ps;
   import frame_buf_pkg::*;

   localparam int max_pix  = 1024;
   localparam int max_half = 1024;

   logic [15:0] pix [max_pix];
   logic [15:0] hdr [header_words];
   int          npix;
   int          nhdr;
   bit          in_frame;
   logic [15:0] exp_mem [queue_depth][max_half];
   int          exp_half [queue_depth];       // frame length in 16-bit words
   int          q_rd;
   int          q_wr;
   int          q_cnt;
   bit          in_session;
   bit          overrun_seen;
   int          cur;
   int          cur_n;
   int          got;

   ///////////////////////////////////////////////////////////////////////
   // frame model
   ///////////////////////////////////////////////////////////////////////
   task automatic commit_frame();
      int len;
      int i;
      len = burst_bytes * (1 + (npix + 2 * burst_words - 1) / (2 * burst_words));
      if (q_cnt == queue_depth)
         return;                          // no room, whole frame dropped
      for (i = 0; i < max_half; i++)
         exp_mem[q_wr][i] = '0;
      exp_mem[q_wr][0] = 16'(len);        // word 1 is the upper half, zero
      for (i = 2; i < nhdr; i++)
         exp_mem[q_wr][i] = hdr[i];
      for (i = 0; i < npix; i++)
         exp_mem[q_wr][2 * burst_words + i] = pix[i];   // pixels after header burst
      exp_half[q_wr] = len / 2;
      q_wr  = (q_wr + 1) % queue_depth;
      q_cnt = q_cnt + 1;
   endtask

   task automatic snoop_stream();
      if (!enable) begin
         q_cnt    = 0;                    // flush
         q_rd     = 0;
         q_wr     = 0;
         in_frame = 0;
      end else if (dvi) begin
         case (dtypei)
            dtype_frame_start: begin
               in_frame = 1;
               npix     = 0;
               nhdr     = 0;
            end
            dtype_pixel: begin
               if (in_frame && npix < max_pix) begin
                  pix[npix] = datai;
                  npix      = npix + 1;
               end
            end
            dtype_header_start: nhdr = 0;
            dtype_header: begin
               if (in_frame && nhdr < header_words) begin
                  hdr[nhdr] = datai;
                  nhdr      = nhdr + 1;
               end
            end
            dtype_header_end: begin
               if (in_frame)
                  commit_frame();
               in_frame = 0;
            end
            default: ;                    // other types are not stored
         endcase
      end
   endtask

   ///////////////////////////////////////////////////////////////////////
   // playback compare
   ///////////////////////////////////////////////////////////////////////
   task automatic watch_reader();
      if (di_read_mode && !in_session) begin
         in_session   = 1;
         overrun_seen = 0;
         got          = 0;
         cur          = q_rd;
         cur_n        = 0;
         if (q_cnt > 0) begin             // the DUT pops the head now
            cur_n = exp_half[q_rd];
            q_rd  = (q_rd + 1) % queue_depth;
            q_cnt = q_cnt - 1;
         end
      end else if (in_session && !di_read_mode) begin
         in_session = 0;
         checks     = checks + 1;
         if (got != cur_n) begin
            errors = errors + 1;
            $display("read session gave %0d words where %0d were expected", got, cur_n);
         end
      end
      if (in_session) begin
         if (di_read_rdy && got >= cur_n && !overrun_seen) begin
            overrun_seen = 1;
            errors       = errors + 1;
            $display("reader offered a word after the end of the frame at %0t", $time);
         end
         if (di_read && di_read_rdy) begin
            if (got < cur_n) begin
               checks = checks + 1;
               if (di_reg_datao !== exp_mem[cur][got]) begin
                  errors = errors + 1;
                  $display("error: di_reg_datao word %0d expected %h actual %h",
                           got, exp_mem[cur][got], di_reg_datao);
               end
            end
            got = got + 1;
         end
      end
   endtask

   // inputs change on the falling edge, so the rising edge sees them settled
   always @(posedge rclk) begin
      if (!resetb) begin
         errors     = 0;
         checks     = 0;
         q_cnt      = 0;
         q_rd       = 0;
         q_wr       = 0;
         in_frame   = 0;
         in_session = 0;
      end else begin
         snoop_stream();
         watch_reader();
      end
   end

endmodule

//--- tb_frame_buf.sv
// frame buffer testbench
// writes a table of frames through the stream port, reads them back over
// the device interface and leaves the comparing to the checker
module tb_frame_buf;
   timeunit 1ns;
   timeprecision 100ps;
   import frame_buf_pkg::*;

   localparam int n_rows      = 10;
   localparam int gap_cycles  = 48;      // lets both ping-pong bursts drain
   localparam int rdy_timeout = 100;
   localparam int hold_cycles = 40;

   typedef struct packed {
      int          pixels;
      logic [15:0] seed;                 // header words are seed + index
      int          others;
      bit          toggle_en;
      bit          kept;
      int          len;                  // rounded length in bytes
      int          reads;                // read sessions after this row
   } row_t;

   ///////////////////////////////////////////////////////////////////////
   // stimulus table
   ///////////////////////////////////////////////////////////////////////
   localparam row_t rows [n_rows] = '{
      '{pixels: 21,  seed: 16'h1a00, others: 3, toggle_en: 0, kept: 1, len: 128, reads: 1},
      '{pixels: 64,  seed: 16'h2b10, others: 0, toggle_en: 0, kept: 1, len: 192, reads: 0},
      '{pixels: 200, seed: 16'h3c20, others: 5, toggle_en: 0, kept: 1, len: 512, reads: 0},
      '{pixels: 33,  seed: 16'h4d30, others: 2, toggle_en: 0, kept: 1, len: 192, reads: 0},
      '{pixels: 7,   seed: 16'h5e40, others: 0, toggle_en: 0, kept: 1, len: 128, reads: 0},
      '{pixels: 40,  seed: 16'h6f50, others: 1, toggle_en: 0, kept: 0, len: 192, reads: 5},
      '{pixels: 15,  seed: 16'h7061, others: 0, toggle_en: 0, kept: 1, len: 128, reads: 1},
      '{pixels: 10,  seed: 16'h8172, others: 0, toggle_en: 0, kept: 1, len: 128, reads: 0},
      '{pixels: 12,  seed: 16'h9283, others: 2, toggle_en: 0, kept: 1, len: 128, reads: 0},
      '{pixels: 25,  seed: 16'ha394, others: 1, toggle_en: 1, kept: 1, len: 128, reads: 2}
   };

   logic        rclk;
   logic        resetb;
   logic        enable;
   logic        dvi;
   dtype_t      dtypei;
   logic [15:0] datai;
   logic        di_read_mode;
   logic        di_read;
   logic        di_read_rdy;
   logic [15:0] di_reg_datao;
   int          chk_errors;
   int          chk_checks;
   int          drv_errors;
   int          seed;
   int          kept_len [$];            // lengths of frames expected in the queue

   frame_buf_top u_dut (
      .rclk         (rclk),
      .resetb       (resetb),
      .enable       (enable),
      .dvi          (dvi),
      .dtypei       (dtypei),
      .datai        (datai),
      .di_read_mode (di_read_mode),
      .di_read      (di_read),
      .di_read_rdy  (di_read_rdy),
      .di_reg_datao (di_reg_datao)
   );

   tb_frame_checker u_chk (
      .rclk         (rclk),
      .resetb       (resetb),
      .enable       (enable),
      .dvi          (dvi),
      .dtypei       (dtypei),
      .datai        (datai),
      .di_read_mode (di_read_mode),
      .di_read      (di_read),
      .di_read_rdy  (di_read_rdy),
      .di_reg_datao (di_reg_datao),
      .errors       (chk_errors),
      .checks       (chk_checks)
   );

   initial begin
      rclk = 1'b0;
      forever #20 rclk = ~rclk;
   end

   // written items plus words read back, 4 cycles each, and 200 per frame
   function automatic int cycle_limit();
      int total;
      int r;
      total = 0;
      for (r = 0; r < n_rows; r++)
         total += 4 * (rows[r].pixels + rows[r].others + header_words + 4 + rows[r].len / 2)
                  + 200;
      return total;
   endfunction

   ///////////////////////////////////////////////////////////////////////
   // driver tasks, all start and end just after a falling edge
   ///////////////////////////////////////////////////////////////////////
   task automatic idle_cycles(input int n);
      repeat (n) @(negedge rclk);
   endtask

   task automatic send_item(input dtype_t t, input logic [15:0] d);
      dvi    = 1'b1;
      dtypei = t;
      datai  = d;
      @(negedge rclk);
      dvi = 1'b0;                        // one item every 2 cycles at most
      @(negedge rclk);
   endtask

   task automatic send_frame(input row_t row);
      int i;
      int n_other;
      n_other = 0;
      send_item(dtype_frame_start, 16'h0000);
      for (i = 0; i < row.pixels; i++) begin
         send_item(dtype_pixel, 16'($random(seed)));
         if (i % 3 == 1 && n_other < row.others) begin
            send_item(dtype_other, 16'hbeef ^ 16'(i));
            n_other++;
         end
      end
      send_item(dtype_frame_end, 16'h0000);
      idle_cycles(gap_cycles);
      send_item(dtype_header_start, 16'h0000);
      for (i = 0; i < header_words; i++)
         send_item(dtype_header, row.seed + 16'(i));
      send_item(dtype_header_end, 16'h0000);
      idle_cycles(gap_cycles);
   endtask

   task automatic toggle_enable();
      enable = 1'b0;
      idle_cycles(4);
      enable = 1'b1;
      idle_cycles(2);
      kept_len.delete();
   endtask

   task automatic read_back(input int n);
      int w;
      int waited;
      di_read_mode = 1'b1;
      for (w = 0; w < n; w++) begin
         waited = 0;
         @(negedge rclk);
         while (!di_read_rdy && waited < rdy_timeout) begin
            @(negedge rclk);
            waited++;
         end
         if (!di_read_rdy) begin
            drv_errors++;
            $display("reader did not offer word %0d of %0d within %0d cycles",
                     w, n, rdy_timeout);
            break;
         end
         di_read = 1'b1;
         @(negedge rclk);
         di_read = 1'b0;
      end
      idle_cycles(hold_cycles);          // rdy must stay low past the end
      di_read_mode = 1'b0;
      idle_cycles(4);
   endtask

   initial begin : watchdog
      int limit;
      int cycles;
      limit  = cycle_limit();
      cycles = 0;
      while (cycles < limit) begin
         @(posedge rclk);
         cycles++;
      end
      $display("timeout after %0d cycles, the run did not complete", limit);
      $display("checks %0d, checker errors %0d, driver errors %0d",
               chk_checks, chk_errors, drv_errors);
      $display("Simulation failed");
      $finish;
   end

   initial begin : stimulus
      int r;
      int k;
      int n;
      seed         = 32'h339b_cfdf;
      drv_errors   = 0;
      resetb       = 1'b0;
      enable       = 1'b1;
      dvi          = 1'b0;
      dtypei       = dtype_other;
      datai        = 16'h0000;
      di_read_mode = 1'b0;
      di_read      = 1'b0;
      idle_cycles(10);
      resetb = 1'b1;
      idle_cycles(2);
      for (r = 0; r < n_rows; r++) begin
         if (rows[r].toggle_en)
            toggle_enable();
         send_frame(rows[r]);
         if (rows[r].kept)
            kept_len.push_back(rows[r].len);
         for (k = 0; k < rows[r].reads; k++) begin
            n = 0;
            if (kept_len.size() > 0)
               n = kept_len.pop_front() / 2;   // empty queue reads nothing
            read_back(n);
         end
      end
      idle_cycles(10);
      $display("checks %0d, checker errors %0d, driver errors %0d",
               chk_checks, chk_errors, drv_errors);
      if (chk_errors == 0 && drv_errors == 0 && chk_checks > 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- verilog.f
frame_buf_pkg.sv
burst_if.sv
stream_writer.sv
frame_queue.sv
mem_bank.sv
di_reader.sv
frame_buf_top.sv
tb_frame_checker.sv
tb_frame_buf.sv
